//--- logic/videoPkg.sv
// raster-side types for the pixel source, the timing generator and the top level.
package videoPkg;

	// one 24-bit RGB pixel, red in the top byte.
	typedef struct packed
	{
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} pixelT;

	// sync levels for one pixel position.
	// de is high in the visible area only.
	typedef struct packed
	{
		logic hSync;
		logic vSync;
		logic de;
	} syncT;

endpackage : videoPkg

//--- logic/tmdsPkg.sv
// TMDS link types, symbol length and control codes shared by the encoder and serializer.
package tmdsPkg;

	// serializer ratio, ten lane bits per pixel clock.
	localparam int symbolBits = 10;

	// one TMDS symbol, bit 0 leaves first.
	typedef logic [symbolBits-1:0] symbolT;

	// control symbols sent during blanking.
	// named after the {vSync, hSync} pair that selects them.
	typedef enum logic [symbolBits-1:0]
	{
		ctrl00 = 10'b1101010100,
		ctrl01 = 10'b0010101011,
		ctrl10 = 10'b0101010100,
		ctrl11 = 10'b1010101011
	} ctrlSymE;

endpackage : tmdsPkg

//--- logic/videoTiming.sv
// raster timing generator; sweeps x and y and decodes the pixel request and sync levels.
`timescale 1ns/100ps

module videoTiming import videoPkg::*;
#(
	parameter integer hDisp = 1024,
	parameter integer hFront = 24,
	parameter integer hSyncLen = 136,
	parameter integer hBack = 160,
	parameter integer vDisp = 600,
	parameter integer vFront = 3,
	parameter integer vSyncLen = 6,
	parameter integer vBack = 29
)
(
	input  logic        clk,
	input  logic        rstN,
	output logic [15:0] x,
	output logic [15:0] y,
	output syncT        sync
);

	localparam integer hTotal = hDisp + hFront + hSyncLen + hBack;
	localparam integer vTotal = vDisp + vFront + vSyncLen + vBack;

	localparam integer hSyncStart = hDisp + hFront;
	localparam integer hSyncEnd = hSyncStart + hSyncLen;
	localparam integer vSyncStart = vDisp + vFront;
	localparam integer vSyncEnd = vSyncStart + vSyncLen;

	logic [15:0] xNext;
	logic [15:0] yNext;
	logic        lineEnd;
	syncT        syncNext;

	// counter values for the next cycle.
	always_comb
	begin
		lineEnd = (x == 16'(hTotal - 1));
		xNext = lineEnd ? 16'd0 : x + 16'd1;
		if (lineEnd)
			yNext = (y == 16'(vTotal - 1)) ? 16'd0 : y + 16'd1;
		else
			yNext = y;
	end

	// decode from the next values so x, y and sync land together.
	always_comb
	begin
		syncNext.de = (xNext < hDisp) && (yNext < vDisp);
		syncNext.hSync = (xNext >= hSyncStart) && (xNext < hSyncEnd);
		syncNext.vSync = (yNext >= vSyncStart) && (yNext < vSyncEnd);
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			x <= '0;
			y <= '0;
			sync <= '0;
		end
		else
		begin
			x <= xNext;
			y <= yNext;
			sync <= syncNext;
		end
	end

endmodule : videoTiming

//--- logic/tmdsEncoder.sv
// TMDS 8b/10b encoder for one lane; data symbols with running DC balance, control codes in blanking.
`timescale 1ns/100ps

module tmdsEncoder import tmdsPkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	input  logic [7:0] data,
	input  logic [1:0] ctrl,
	input  logic       de,
	output symbolT     symbol
);

	// number of ones in a byte.
	function automatic logic [3:0] countOnes(input logic [7:0] v);
		logic [3:0] n;
		n = 4'd0;
		for (int i = 0; i < 8; i++)
			n = n + 4'(v[i]);
		return n;
	endfunction

	logic [3:0]        dataOnes;
	logic              useXnor;
	logic [8:0]        qm;      // transition-minimised word.
	logic signed [3:0] balance;  // ones minus zeros of qm[7:0], halved.
	logic signed [3:0] disparity;
	logic signed [3:0] dispStep;
	logic signed [3:0] dispNext;
	logic              evenCase;
	logic              signMatch;
	logic              invert;
	symbolT            dataSym;
	ctrlSymE           ctrlSym;

	// stage one, xor or xnor chain.
	always_comb
	begin
		dataOnes = countOnes(data);
		useXnor = (dataOnes > 4'd4) || (dataOnes == 4'd4 && !data[0]);
		qm[0] = data[0];
		for (int i = 1; i < 8; i++)
			qm[i] = useXnor ? ~(qm[i-1] ^ data[i]) : (qm[i-1] ^ data[i]);
		qm[8] = ~useXnor; // 1 marks xor.
	end

	// stage two, pick polarity against the running disparity.
	always_comb
	begin
		balance = $signed(countOnes(qm[7:0]) - 4'd4);
		evenCase = (balance == 4'sd0) || (disparity == 4'sd0);
		signMatch = (balance[3] == disparity[3]);
		invert = evenCase ? ~qm[8] : signMatch;
		// correction for the qm[8] bit when the word is flipped against it.
		dispStep = balance - $signed({3'b000, (qm[8] ^ ~signMatch) & ~evenCase});
		dispNext = invert ? disparity - dispStep : disparity + dispStep;
		dataSym = {invert, qm[8], qm[7:0] ^ {8{invert}}};
	end

	// control code during blanking.
	always_comb
	begin
		case (ctrl)
			2'b00: ctrlSym = ctrl00;
			2'b01: ctrlSym = ctrl01;
			2'b10: ctrlSym = ctrl10;
			default: ctrlSym = ctrl11;
		endcase
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			symbol <= '0;
			disparity <= 4'sd0;
		end
		else
		begin
			symbol <= de ? dataSym : symbolT'(ctrlSym);
			disparity <= de ? dispNext : 4'sd0; // cleared in every blanking period.
		end
	end

endmodule : tmdsEncoder

//--- logic/tmdsSerializer.sv
// 10:1 serializer for one TMDS lane; loads a symbol every ten serial cycles, sends LSB first.
`timescale 1ns/100ps

module tmdsSerializer import tmdsPkg::*;
(
	input  logic   tmdsClk,
	input  logic   rstN,
	input  symbolT symbol,
	output logic   lane
);

	localparam int cntBits = $clog2(symbolBits);
	localparam logic [cntBits-1:0] lastCount = cntBits'(symbolBits - 1);

	logic [cntBits-1:0] bitCount; // serial phase within a symbol.
	logic               load;
	symbolT             shiftReg;

	// modulo-10 phase counter.
	always_ff @(posedge tmdsClk or negedge rstN)
	begin
		if (!rstN)
			bitCount <= '0;
		else if (bitCount == lastCount)
			bitCount <= '0;
		else
			bitCount <= bitCount + 1'b1;
	end

	// load one cycle after the last phase.
	// this keeps the capture clear of the pixel clock edge.
	always_ff @(posedge tmdsClk or negedge rstN)
	begin
		if (!rstN)
			load <= 1'b0;
		else
			load <= (bitCount == lastCount);
	end

	always_ff @(posedge tmdsClk or negedge rstN)
	begin
		if (!rstN)
			shiftReg <= '0;
		else if (load)
			shiftReg <= symbol;
		else
			shiftReg <= shiftReg >> 1; // next bit down to the lane.
	end

	assign lane = shiftReg[0];

endmodule : tmdsSerializer

//--- logic/hdmiTransmitter.sv
// DVI-mode HDMI transmitter top; timing, pixel register, three TMDS encoders and serializers.
`timescale 1ns/100ps

module hdmiTransmitter import videoPkg::*, tmdsPkg::*;
#(
	parameter integer hDisp = 1024,
	parameter integer hFront = 24,
	parameter integer hSyncLen = 136,
	parameter integer hBack = 160,
	parameter integer vDisp = 600,
	parameter integer vFront = 3,
	parameter integer vSyncLen = 6,
	parameter integer vBack = 29
)
(
	input  logic        clk,
	input  logic        tmdsClk,   // ten times clk, phase locked.
	input  logic        rstN,
	input  pixelT       pixelData,
	output logic        request,
	output logic [15:0] x,
	output logic [15:0] y,
	output logic        d0,        // blue.
	output logic        d1,        // green.
	output logic        d2,        // red.
	output logic        tmdsClkOut
);

	syncT   sync;
	syncT   syncQ;
	pixelT  pixelQ;
	symbolT symR;
	symbolT symG;
	symbolT symB;

	videoTiming #(
		.hDisp(hDisp), .hFront(hFront), .hSyncLen(hSyncLen), .hBack(hBack),
		.vDisp(vDisp), .vFront(vFront), .vSyncLen(vSyncLen), .vBack(vBack)
	) uTiming (
		.clk(clk), .rstN(rstN), .x(x), .y(y), .sync(sync)
	);

	assign request = sync.de;

	// pixel arrives in the request cycle.
	always_ff @(posedge clk)
		pixelQ <= pixelData;

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
			syncQ <= '0;
		else
			syncQ <= sync;
	end

	// sync rides on the blue lane only.
	tmdsEncoder uEncR (.clk(clk), .rstN(rstN), .data(pixelQ.red), .ctrl(2'b00),
		.de(syncQ.de), .symbol(symR));
	tmdsEncoder uEncG (.clk(clk), .rstN(rstN), .data(pixelQ.green), .ctrl(2'b00),
		.de(syncQ.de), .symbol(symG));
	tmdsEncoder uEncB (.clk(clk), .rstN(rstN), .data(pixelQ.blue),
		.ctrl({syncQ.vSync, syncQ.hSync}), .de(syncQ.de), .symbol(symB));

	tmdsSerializer uSerR (.tmdsClk(tmdsClk), .rstN(rstN), .symbol(symR), .lane(d2));
	tmdsSerializer uSerG (.tmdsClk(tmdsClk), .rstN(rstN), .symbol(symG), .lane(d1));
	tmdsSerializer uSerB (.tmdsClk(tmdsClk), .rstN(rstN), .symbol(symB), .lane(d0));

	assign tmdsClkOut = clk; // clock lane.

endmodule : hdmiTransmitter

//--- bench/hdmiTransmitter_props.sv
// concurrent assertions on raster counters and serializer load rhythm, bound into the transmitter top.
`timescale 1ns/100ps

module hdmiTransmitter_props
#(
	parameter integer hDisp = 1024,
	parameter integer hTotal = 1344
)
(
	input logic        clk,
	input logic        tmdsClk,
	input logic        rstN,
	input logic [15:0] x,
	input logic        request,
	input logic        loadR,
	input logic        loadG,
	input logic        loadB
);

	// one load, then nine quiet cycles, then the next.
	property loadEveryTen(load);
		@(posedge tmdsClk) disable iff (!rstN)
			load |=> !load [*9] ##1 load;
	endproperty

	xInRange: assert property (@(posedge clk) disable iff (!rstN) x < hTotal)
		else $error("x reached hTotal");

	requestVisible: assert property (@(posedge clk) disable iff (!rstN) request |-> x < hDisp)
		else $error("request outside the visible columns");

	loadRedLane: assert property (loadEveryTen(loadR)) else $error("red load rhythm broken");
	loadGreenLane: assert property (loadEveryTen(loadG)) else $error("green load rhythm broken");
	loadBlueLane: assert property (loadEveryTen(loadB)) else $error("blue load rhythm broken");

endmodule : hdmiTransmitter_props

bind hdmiTransmitter hdmiTransmitter_props #(
	.hDisp(hDisp), .hTotal(hDisp + hFront + hSyncLen + hBack)
) uProps (
	.clk(clk), .tmdsClk(tmdsClk), .rstN(rstN), .x(x), .request(request),
	.loadR(uSerR.load), .loadG(uSerG.load), .loadB(uSerB.load)
);

//--- bench/hdmiTb.sv
// testbench for the HDMI transmitter; random pixels in, lanes deserialized and checked against a model.
`timescale 1ns/100ps

module hdmiTb import videoPkg::*, tmdsPkg::*;
;

	localparam integer hDisp = 8;
	localparam integer hFront = 2;
	localparam integer hSyncLen = 3;
	localparam integer hBack = 3;
	localparam integer vDisp = 4;
	localparam integer vFront = 1;
	localparam integer vSyncLen = 2;
	localparam integer vBack = 1;
	localparam integer hTotal = hDisp + hFront + hSyncLen + hBack;
	localparam integer vTotal = vDisp + vFront + vSyncLen + vBack;
	localparam integer frameCycles = hTotal * vTotal;
	localparam integer resetCycles = 16;
	localparam integer runCycles = 3 * frameCycles;
	localparam integer clkPeriod = 40;

	logic        clk;
	logic        tmdsClk;
	logic        rstN;
	pixelT       pixelData;
	logic        request;
	logic [15:0] x;
	logic [15:0] y;
	logic        d0;
	logic        d1;
	logic        d2;
	logic        tmdsClkOut;

	pixelT  pixelQueue[$];  // pixels handed to the DUT, oldest first.
	syncT   cycleQueue[$];  // expected sync and de per clk cycle.
	int     mX;
	int     mY;
	bit     started;
	syncT   cyc;
	bit     expReq;
	int     cntR;
	int     cntG;
	int     cntB;
	int     rxDispR;
	int     rxDispG;
	int     rxDispB;
	symbolT winR;
	symbolT winG;
	symbolT winB;
	bit     aligned;
	int     phase;
	bit     dataSeen;
	int     bitsInPeriod;
	bit     periodArmed;
	int     dataCount;

	hdmiTransmitter #(
		.hDisp(hDisp), .hFront(hFront), .hSyncLen(hSyncLen), .hBack(hBack),
		.vDisp(vDisp), .vFront(vFront), .vSyncLen(vSyncLen), .vBack(vBack)
	) u_hdmiTransmitter (
		.clk(clk), .tmdsClk(tmdsClk), .rstN(rstN), .pixelData(pixelData),
		.request(request), .x(x), .y(y), .d0(d0), .d1(d1), .d2(d2),
		.tmdsClkOut(tmdsClkOut)
	);

	task automatic check(input string name, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("[FAIL] %s: expected %0d, actual %0d", name, expected, actual);
			$display("Simulation FAILED");
			$fatal(1, "check mismatch");
		end
	endtask

	task automatic abortRun(input string what);
		$display("ERROR: %s", what);
		$display("Simulation FAILED");
		$fatal(1, "run aborted");
	endtask

	function automatic int ones10(input symbolT s);
		int n;
		n = 0;
		for (int i = 0; i < 10; i++)
			n += s[i];
		return n;
	endfunction

	function automatic bit isCtrl(input symbolT s);
		return (s == ctrl00) || (s == ctrl01) || (s == ctrl10) || (s == ctrl11);
	endfunction

	// control token from the {vSync, hSync} pair.
	function automatic symbolT ctrlFor(input logic vs, input logic hs);
		case ({vs, hs})
			2'b00: return 10'b1101010100;
			2'b01: return 10'b0010101011;
			2'b10: return 10'b0101010100;
			default: return 10'b1010101011;
		endcase
	endfunction

	// reference 8b/10b encode, cnt in full ones-minus-zeros units.
	task automatic encodeByte(input logic [7:0] d, inout int cnt, output symbolT sym);
		int n1;
		int q1;
		int q0;
		int qm8;
		logic xn;
		logic [8:0] q;
		n1 = 0;
		for (int i = 0; i < 8; i++)
			n1 += d[i];
		xn = (n1 > 4) || (n1 == 4 && d[0] == 1'b0);
		q[0] = d[0];
		for (int i = 1; i < 8; i++)
			q[i] = xn ? ~(q[i-1] ^ d[i]) : (q[i-1] ^ d[i]);
		q[8] = ~xn;
		qm8 = q[8];
		q1 = 0;
		for (int i = 0; i < 8; i++)
			q1 += q[i];
		q0 = 8 - q1;
		if (cnt == 0 || q1 == q0)
		begin
			sym = {~q[8], q[8], (q[8] ? q[7:0] : ~q[7:0])};
			cnt += q[8] ? (q1 - q0) : (q0 - q1);
		end
		else if ((cnt > 0 && q1 > q0) || (cnt < 0 && q0 > q1))
		begin
			sym = {1'b1, q[8], ~q[7:0]};
			cnt += 2 * qm8 + q0 - q1;
		end
		else
		begin
			sym = {1'b0, q[8], q[7:0]};
			cnt += q1 - q0 - 2 * (1 - qm8);
		end
	endtask

	task automatic checkDataLane(input string lane, input logic [7:0] d, input symbolT sym,
		inout int cnt, inout int rxDisp);
		symbolT expSym;
		encodeByte(d, cnt, expSym);
		check({lane, " data symbol"}, expSym, sym);
		rxDisp += ones10(sym) - 5; // halved units.
		check({lane, " disparity within 8"}, 1, (rxDisp >= -8) && (rxDisp <= 8));
	endtask

	// one symbol per lane, matched against the next expected cycle.
	task automatic takeSymbols(input symbolT symR, input symbolT symG, input symbolT symB);
		syncT c;
		pixelT pix;
		if (!dataSeen && isCtrl(symB))
			return; // leading blanking after reset.
		if (!dataSeen)
		begin
			dataSeen = 1'b1;
			while (cycleQueue.size() > 0 && !cycleQueue[0].de)
				void'(cycleQueue.pop_front());
		end
		if (cycleQueue.size() == 0)
			abortRun("a symbol arrived with no expected clk cycle behind it");
		else
		begin
			c = cycleQueue.pop_front();
			if (c.de && pixelQueue.size() == 0)
				abortRun("a data symbol arrived but no pixel was handed out");
			else if (c.de)
			begin
				pix = pixelQueue.pop_front();
				checkDataLane("red", pix.red, symR, cntR, rxDispR);
				checkDataLane("green", pix.green, symG, cntG, rxDispG);
				checkDataLane("blue", pix.blue, symB, cntB, rxDispB);
				dataCount++;
			end
			else
			begin
				check("blue control symbol", ctrlFor(c.vSync, c.hSync), symB);
				check("green control symbol", ctrlFor(1'b0, 1'b0), symG);
				check("red control symbol", ctrlFor(1'b0, 1'b0), symR);
				cntR = 0; // balance starts over each blanking.
				cntG = 0;
				cntB = 0;
				rxDispR = 0;
				rxDispG = 0;
				rxDispB = 0;
			end
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// rising edges line up with clk.
	initial
	begin
		tmdsClk = 1'b0;
		#2;
		forever #2 tmdsClk = ~tmdsClk;
	end

	// pixel source.
	always @(posedge clk)
	begin
		#1;
		if (rstN && request)
		begin
			pixelData = pixelT'($urandom);
			pixelQueue.push_back(pixelData);
		end
		else
			pixelData = '0;
	end

	// raster model, sampled mid cycle.
	always @(negedge clk)
	begin
		if (rstN)
		begin
			check("raster x", mX, x);
			check("raster y", mY, y);
			expReq = started && (mX < hDisp) && (mY < vDisp);
			check("request", expReq, request);
			cyc.de = expReq;
			cyc.hSync = (mX >= hDisp + hFront) && (mX < hDisp + hFront + hSyncLen);
			cyc.vSync = (mY >= vDisp + vFront) && (mY < vDisp + vFront + vSyncLen);
			cycleQueue.push_back(cyc);
			if (mX == hTotal - 1)
			begin
				mX = 0;
				mY = (mY == vTotal - 1) ? 0 : mY + 1;
			end
			else
				mX = mX + 1;
			started = 1'b1;
		end
	end

	// lane bits between rising edges of the forwarded clock.
	always @(posedge tmdsClkOut)
	begin
		if (rstN && aligned)
		begin
			if (periodArmed)
				check("lane bits per clk period", 10, bitsInPeriod);
			periodArmed = 1'b1;
			bitsInPeriod = 0;
		end
	end

	// lane deserializers.
	always @(negedge tmdsClk)
	begin
		if (rstN)
		begin
			check("clock lane", clk, tmdsClkOut);
			winR = {d2, winR[9:1]}; // first bit ends up in bit 0.
			winG = {d1, winG[9:1]};
			winB = {d0, winB[9:1]};
			if (aligned)
			begin
				bitsInPeriod++;
				phase++;
				if (phase == 10)
				begin
					phase = 0;
					takeSymbols(winR, winG, winB);
				end
			end
			else if (isCtrl(winB))
			begin
				aligned = 1'b1;
				phase = 0;
				bitsInPeriod = 0;
				takeSymbols(winR, winG, winB);
			end
		end
	end

	initial
	begin
		void'($urandom(38));
		rstN = 1'b0;
		pixelData = '0;
		mX = 0;
		mY = 0;
		started = 1'b0;
		{cntR, cntG, cntB} = '0;
		{rxDispR, rxDispG, rxDispB} = '0;
		{winR, winG, winB} = '0;
		aligned = 1'b0;
		phase = 0;
		dataSeen = 1'b0;
		bitsInPeriod = 0;
		periodArmed = 1'b0;
		dataCount = 0;
		repeat (resetCycles) @(posedge clk);
		#1 rstN = 1'b1;
		repeat (runCycles + 20) @(posedge clk);
		check("data symbols received", 1, dataCount >= 3 * hDisp * vDisp);
		$display("Simulation PASSED");
		$finish;
	end

	// watchdog.
	initial
	begin
		#(clkPeriod * (resetCycles + runCycles + 200));
		$display("ERROR: watchdog timeout, the run did not reach its end in time");
		$display("Simulation FAILED");
		$fatal(1, "timeout");
	end

endmodule : hdmiTb

//--- compile.f
logic/videoPkg.sv
logic/tmdsPkg.sv
logic/videoTiming.sv
logic/tmdsEncoder.sv
logic/tmdsSerializer.sv
logic/hdmiTransmitter.sv
bench/hdmiTransmitter_props.sv
bench/hdmiTb.sv

//--- run.sh
#!/bin/sh
# Build and run the HDMI transmitter testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module hdmiTb -f compile.f -o simHdmi
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/simHdmi > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
	echo "run.sh: failure reported in $LOG"
	exit 1
fi

if [ $simStatus -ne 0 ]; then
	echo "run.sh: simulator exited with status $simStatus"
	exit 1
fi

echo "run.sh: no failure found in $LOG"
exit 0
